//--- buffer_pkg.sv
// shared widths, sample and mask types, command and stream structs
// and state encodings for the capture buffer
package buffer_pkg;

  // parallel adc channels, one memory bank each
  localparam int CHANNELS = 4;
  localparam int DATA_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] sample_t;
  // one bit per channel or bank
  typedef logic [CHANNELS-1:0] chan_mask_t;
  // 0 to CHANNELS inclusive
  typedef logic [$clog2(CHANNELS+1)-1:0] chan_count_t;
  typedef logic [$clog2(CHANNELS)-1:0] bank_sel_t;
  // active channels = 1 << mode, modes 0 to 2
  typedef logic [1:0] bank_mode_t;

  typedef struct packed {
    logic arm;
    logic start;
    logic stop;
  } capture_cmd_t;

  // all channels side by side, valid per channel
  typedef struct packed {
    sample_t [CHANNELS-1:0] data;
    chan_mask_t valid;
  } adc_frame_t;

  typedef struct packed {
    sample_t data;
    logic last;
  } readout_beat_t;

  typedef enum logic [1:0] {
    CAPTURE_IDLE,
    TRIGGER_WAIT,
    SAVE_SAMPLES,
    HOLD_SAMPLES
  } capture_state_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READY,
    DMA_ACTIVE
  } readout_state_e;

endpackage

//--- capture_fsm.sv
// capture state machine, banking mode register, start/stop gating
// and the capture done pulse
`timescale 1ns/1ps
module capture_fsm (
  input  logic                     adc_clk,
  input  logic                     adc_reset,
  input  buffer_pkg::capture_cmd_t cmd,
  input  logic                     cmd_valid,
  output logic                     cmd_ready,
  input  buffer_pkg::bank_mode_t   bank_mode,
  input  logic                     bank_mode_valid,
  output logic                     bank_mode_ready,
  input  logic                     capture_hw_start,
  input  logic                     capture_hw_stop,
  input  logic                     capture_full,
  input  logic                     readout_done,
  output logic                     capture_start,
  output logic                     capture_stop,
  output logic                     capture_active,
  output logic                     capture_done,
  output buffer_pkg::chan_count_t  active_channels
);

  buffer_pkg::capture_state_e state;
  buffer_pkg::capture_cmd_t cmd_ok;
  // previous capture_full for the rising edge
  logic full_d;

  // commands are refused while the samples wait for readout
  assign cmd_ready = state != buffer_pkg::HOLD_SAMPLES;
  // mode may only change between captures
  assign bank_mode_ready = state == buffer_pkg::CAPTURE_IDLE;
  // only an accepted command has any effect
  assign cmd_ok = (cmd_valid && cmd_ready) ? cmd : '0;

  // hw start needs arming first and sw start also works straight from idle
  // arm wins over start in idle
  assign capture_start =
    ((state == buffer_pkg::TRIGGER_WAIT) && (capture_hw_start || cmd_ok.start)) ||
    ((state == buffer_pkg::CAPTURE_IDLE) && cmd_ok.start && !cmd_ok.arm);
  assign capture_stop = (state == buffer_pkg::SAVE_SAMPLES) && (capture_hw_stop || cmd_ok.stop);

  ////////////////////////////////////////
  // banking mode
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_channels <= buffer_pkg::chan_count_t'(buffer_pkg::CHANNELS);
    end else if (bank_mode_valid && bank_mode_ready) begin
      active_channels <= buffer_pkg::chan_count_t'(1) << bank_mode;
    end
  end

  ////////////////////////////////////////
  // active flag and done pulse
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      capture_active <= 1'b0;
      capture_done <= 1'b0;
      full_d <= 1'b0;
    end else begin
      full_d <= capture_full;
      // full already shows in the cycle the last bank fills
      if (capture_start) begin
        capture_active <= 1'b1;
      end else if (capture_stop || capture_full) begin
        capture_active <= 1'b0;
      end
      capture_done <= capture_stop || (capture_full && !full_d);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= buffer_pkg::CAPTURE_IDLE;
    end else begin
      unique case (state)
        buffer_pkg::CAPTURE_IDLE: begin
          if (cmd_ok.arm) begin
            state <= buffer_pkg::TRIGGER_WAIT;
          end else if (capture_start) begin
            state <= buffer_pkg::SAVE_SAMPLES;
          end
        end
        buffer_pkg::TRIGGER_WAIT: begin
          if (capture_start) begin
            state <= buffer_pkg::SAVE_SAMPLES;
          end
        end
        buffer_pkg::SAVE_SAMPLES: begin
          if (capture_stop || capture_full) begin
            state <= buffer_pkg::HOLD_SAMPLES;
          end
        end
        // hold until every stored sample has been read out
        buffer_pkg::HOLD_SAMPLES: begin
          if (readout_done) begin
            state <= buffer_pkg::CAPTURE_IDLE;
          end
        end
        default: state <= buffer_pkg::CAPTURE_IDLE;
      endcase
    end
  end

  // start only while no capture runs
  assert property (@(posedge adc_clk) disable iff (adc_reset)
    capture_start |-> !capture_active);
  // stop only while a capture runs
  assert property (@(posedge adc_clk) disable iff (adc_reset)
    capture_stop |-> capture_active);

endmodule

//--- bank_write_counter.sv
// per-bank write address counters, rolling valid mask, full detection
// and the write depth status
`timescale 1ns/1ps
module bank_write_counter #(
  parameter int BUFFER_DEPTH = 256
) (
  input  logic                                                   adc_clk,
  input  logic                                                   adc_reset,
  input  logic                                                   capture_start,
  input  logic                                                   capture_stop,
  input  logic                                                   capture_active,
  input  buffer_pkg::chan_count_t                                active_channels,
  input  buffer_pkg::chan_mask_t                                 write_en,
  input  logic                                                   readout_done,
  output buffer_pkg::chan_mask_t                                 valid_mask,
  output logic [buffer_pkg::CHANNELS-1:0][$clog2(BUFFER_DEPTH)-1:0] write_addr,
  output buffer_pkg::chan_mask_t                                 bank_full,
  output logic                                                   capture_full,
  output logic [buffer_pkg::CHANNELS-1:0][$clog2(BUFFER_DEPTH):0]   write_depth
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int CH = buffer_pkg::CHANNELS;

  // banks whose filling ends the capture, and banks that have filled
  buffer_pkg::chan_mask_t full_mask, full_latch;

  always_comb begin
    for (int b = 0; b < CH; b++) begin
      // top active_channels banks, e.g. 1 channel -> 1000, 2 -> 1100, 4 -> 1111
      full_mask[CH-1-b] = buffer_pkg::chan_count_t'(b) < active_channels;
      // bank takes its last sample this cycle
      bank_full[b] = write_en[b] && (write_addr[b] == ADDR_WIDTH'(BUFFER_DEPTH - 1));
    end
  end

  // goes high in the filling cycle, then held by the latch
  assign capture_full = |(full_mask & (full_latch | bank_full));

  ////////////////////////////////////////
  // rolling valid mask
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_mask <= '0;
    end else if (capture_start) begin
      // lowest active_channels banks take the first samples
      for (int b = 0; b < CH; b++) begin
        valid_mask[b] <= buffer_pkg::chan_count_t'(b) < active_channels;
      end
    end else if (capture_active) begin
      for (int b = 0; b < CH; b++) begin
        if (bank_full[b]) begin
          valid_mask[b] <= 1'b0;
          // hand over to the bank one channel group further up
          if (valid_mask[b] &&
              (buffer_pkg::chan_count_t'(b) + active_channels <
               buffer_pkg::chan_count_t'(CH))) begin
            valid_mask[buffer_pkg::bank_sel_t'(buffer_pkg::chan_count_t'(b) +
                                                active_channels)] <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // addresses and full latches
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset || readout_done) begin
      write_addr <= '0;
      full_latch <= '0;
    end else begin
      for (int b = 0; b < CH; b++) begin
        if (write_en[b]) begin
          write_addr[b] <= write_addr[b] + 1'b1;
        end
        if (bank_full[b]) begin
          full_latch[b] <= 1'b1;
        end
      end
    end
  end

  // next-cycle view, so the value is complete when capture_done fires
  // a full bank wraps its count to 0 and shows as exactly BUFFER_DEPTH
  always_ff @(posedge adc_clk) begin
    for (int b = 0; b < CH; b++) begin
      write_depth[b] <= {full_latch[b] | bank_full[b],
                         write_addr[b] + ADDR_WIDTH'(write_en[b])};
    end
  end

  // a filled bank stays untouched until readout clears it
  assert property (@(posedge adc_clk) disable iff (adc_reset) (write_en & full_latch) == '0);
  // the mux stops issuing writes right after a stop
  assert property (@(posedge adc_clk) disable iff (adc_reset) capture_stop |=> write_en == '0);

endmodule

//--- sample_mux.sv
// input frame register and banking mode data/valid mux that forms
// the bank write enables
`timescale 1ns/1ps
module sample_mux (
  input  logic                                    adc_clk,
  input  buffer_pkg::adc_frame_t                  adc_in,
  input  buffer_pkg::chan_count_t                 active_channels,
  input  buffer_pkg::chan_mask_t                  valid_mask,
  input  logic                                    capture_active,
  output buffer_pkg::chan_mask_t                  write_en_now,
  output buffer_pkg::chan_mask_t                  write_en,
  output buffer_pkg::sample_t [buffer_pkg::CHANNELS-1:0] write_data
);

  localparam int CH = buffer_pkg::CHANNELS;

  // first pipeline stage, input frame
  buffer_pkg::adc_frame_t frame_d;
  // source channel of each bank
  buffer_pkg::bank_sel_t chan_sel [CH];

  always_ff @(posedge adc_clk) begin
    frame_d <= adc_in;
  end

  always_comb begin
    for (int b = 0; b < CH; b++) begin
      // b mod active_channels, active_channels is a power of two
      chan_sel[b] = buffer_pkg::bank_sel_t'(b) &
                    buffer_pkg::bank_sel_t'(active_channels - 1'b1);
      // unregistered enable feeds the address counters
      write_en_now[b] = capture_active && valid_mask[b] && frame_d.valid[chan_sel[b]];
    end
  end

  ////////////////////////////////////////
  // second stage, lines up with the
  // delayed write address
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    for (int b = 0; b < CH; b++) begin
      write_data[b] <= frame_d.data[chan_sel[b]];
    end
    write_en <= write_en_now;
  end

endmodule

//--- sample_memory.sv
// banked sample storage, one write port per bank and a shared
// read address with a READ_LATENCY stage pipeline
`timescale 1ns/1ps
module sample_memory #(
  parameter int BUFFER_DEPTH = 256,
  parameter int READ_LATENCY = 4
) (
  input  logic                                                   adc_clk,
  input  buffer_pkg::chan_mask_t                                 write_en,
  input  logic [buffer_pkg::CHANNELS-1:0][$clog2(BUFFER_DEPTH)-1:0] write_addr,
  input  buffer_pkg::sample_t [buffer_pkg::CHANNELS-1:0]         write_data,
  input  logic                                                   read_en,
  input  logic [$clog2(BUFFER_DEPTH)-1:0]                        read_addr,
  output buffer_pkg::sample_t [buffer_pkg::CHANNELS-1:0]         read_data
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int CH = buffer_pkg::CHANNELS;

  buffer_pkg::sample_t mem [CH][BUFFER_DEPTH];
  // counter address is one cycle ahead of the registered data
  logic [CH-1:0][ADDR_WIDTH-1:0] write_addr_d;
  buffer_pkg::sample_t [CH-1:0][READ_LATENCY-1:0] read_pipe;

  always_ff @(posedge adc_clk) begin
    write_addr_d <= write_addr;
    for (int b = 0; b < CH; b++) begin
      if (write_en[b]) begin
        mem[b][write_addr_d[b]] <= write_data[b];
      end
    end
  end

  // whole pipeline freezes under back-pressure
  always_ff @(posedge adc_clk) begin
    if (read_en) begin
      for (int b = 0; b < CH; b++) begin
        read_pipe[b] <= {read_pipe[b][READ_LATENCY-2:0], mem[b][read_addr]};
      end
    end
  end

  always_comb begin
    for (int b = 0; b < CH; b++) begin
      read_data[b] = read_pipe[b][READ_LATENCY-1];
    end
  end

endmodule

//--- readout_stream.sv
// readout state machine, read address and bank counter, aligned
// valid/last/bank pipeline and the output register
`timescale 1ns/1ps
module readout_stream #(
  parameter int BUFFER_DEPTH = 256,
  parameter int READ_LATENCY = 4
) (
  input  logic                                           adc_clk,
  input  logic                                           adc_reset,
  input  logic                                           capture_done,
  input  logic                                           readout_start_valid,
  output logic                                           readout_start_ready,
  output logic                                           read_en,
  output logic [$clog2(BUFFER_DEPTH)-1:0]                read_addr,
  input  buffer_pkg::sample_t [buffer_pkg::CHANNELS-1:0] read_data,
  output buffer_pkg::readout_beat_t                      readout_data,
  output logic                                           readout_valid,
  input  logic                                           readout_ready,
  output logic                                           readout_done
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int CH = buffer_pkg::CHANNELS;

  buffer_pkg::readout_state_e state;
  logic done_d;
  // start pulse, then active one cycle later
  logic start_pls, active;
  // address counter sits on the final word of the final bank
  logic at_end;
  logic advance;
  buffer_pkg::bank_sel_t bank_sel;
  logic [READ_LATENCY-1:0] valid_pipe, last_pipe;
  buffer_pkg::bank_sel_t [READ_LATENCY-1:0] bank_pipe;
  buffer_pkg::sample_t out_data;
  logic out_last;

  assign readout_start_ready = state == buffer_pkg::DMA_READY;
  // pipeline moves when the output slot is free or being taken
  assign read_en = readout_ready || !readout_valid;
  assign advance = active && read_en;
  assign at_end = (read_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) &&
                  (bank_sel == buffer_pkg::bank_sel_t'(CH - 1));
  assign readout_data = '{data: out_data, last: out_last};
  assign readout_done = readout_valid && readout_ready && out_last;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      done_d <= 1'b0;
      start_pls <= 1'b0;
      active <= 1'b0;
    end else begin
      done_d <= capture_done;
      // ready is still high the cycle after a start, so block a second pulse
      start_pls <= readout_start_valid && readout_start_ready && !start_pls;
      if (start_pls) begin
        active <= 1'b1;
      end else if (advance && at_end) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      state <= buffer_pkg::DMA_IDLE;
    end else begin
      unique case (state)
        buffer_pkg::DMA_IDLE: if (done_d) state <= buffer_pkg::DMA_READY;
        buffer_pkg::DMA_READY: if (start_pls) state <= buffer_pkg::DMA_ACTIVE;
        buffer_pkg::DMA_ACTIVE: if (readout_done) state <= buffer_pkg::DMA_IDLE;
        default: state <= buffer_pkg::DMA_IDLE;
      endcase
    end
  end

  // walk bank 0 first, every address, then the next bank
  always_ff @(posedge adc_clk) begin
    if (adc_reset || start_pls) begin
      read_addr <= '0;
      bank_sel <= '0;
    end else if (advance) begin
      if (read_addr == ADDR_WIDTH'(BUFFER_DEPTH - 1)) begin
        read_addr <= '0;
        bank_sel <= at_end ? '0 : bank_sel + 1'b1;
      end else begin
        read_addr <= read_addr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // pipelines matched to memory latency
  ////////////////////////////////////////
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_pipe <= '0;
      last_pipe <= '0;
      readout_valid <= 1'b0;
      out_last <= 1'b0;
    end else if (read_en) begin
      valid_pipe <= {valid_pipe[READ_LATENCY-2:0], active};
      last_pipe <= {last_pipe[READ_LATENCY-2:0], active && at_end};
      readout_valid <= valid_pipe[READ_LATENCY-1];
      out_last <= last_pipe[READ_LATENCY-1];
    end
  end

  // output mux picks the bank the word was read from
  always_ff @(posedge adc_clk) begin
    if (read_en) begin
      bank_pipe <= {bank_pipe[READ_LATENCY-2:0], bank_sel};
      out_data <= read_data[bank_pipe[READ_LATENCY-1]];
    end
  end

  // stalled beat holds until the sink takes it
  assert property (@(posedge adc_clk) disable iff (adc_reset)
    readout_valid && !readout_ready |=> readout_valid && $stable(readout_data));

endmodule

//--- buffer_top.sv
// top level of the sample capture buffer, connects capture control,
// write counters, sample mux, banked memory and readout
`timescale 1ns/1ps
module buffer_top #(
  parameter int BUFFER_DEPTH = 256,
  parameter int READ_LATENCY = 4
) (
  input  logic                                                 adc_clk,
  input  logic                                                 adc_reset,
  input  buffer_pkg::adc_frame_t                               adc_in,
  input  logic                                                 capture_hw_start,
  input  logic                                                 capture_hw_stop,
  output logic                                                 capture_full,
  input  buffer_pkg::capture_cmd_t                             cmd,
  input  logic                                                 cmd_valid,
  output logic                                                 cmd_ready,
  input  buffer_pkg::bank_mode_t                               bank_mode,
  input  logic                                                 bank_mode_valid,
  output logic                                                 bank_mode_ready,
  input  logic                                                 readout_start_valid,
  output logic                                                 readout_start_ready,
  output buffer_pkg::readout_beat_t                            readout_data,
  output logic                                                 readout_valid,
  input  logic                                                 readout_ready,
  output logic [buffer_pkg::CHANNELS-1:0][$clog2(BUFFER_DEPTH):0] write_depth,
  output logic                                                 write_depth_valid
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);
  localparam int CH = buffer_pkg::CHANNELS;

  logic capture_start, capture_stop, capture_active, capture_done;
  logic readout_done;
  buffer_pkg::chan_count_t active_channels;
  buffer_pkg::chan_mask_t valid_mask, write_en_now, write_en;
  logic [CH-1:0][ADDR_WIDTH-1:0] write_addr;
  buffer_pkg::sample_t [CH-1:0] write_data, read_data;
  logic read_en;
  logic [ADDR_WIDTH-1:0] read_addr;

  // status leaves together with the done pulse
  assign write_depth_valid = capture_done;

  capture_fsm capture_fsm_i (
    .adc_clk, .adc_reset,
    .cmd, .cmd_valid, .cmd_ready,
    .bank_mode, .bank_mode_valid, .bank_mode_ready,
    .capture_hw_start, .capture_hw_stop,
    .capture_full, .readout_done,
    .capture_start, .capture_stop, .capture_active, .capture_done,
    .active_channels
  );

  // per-bank fill strobes only feed capture_full inside the counter
  bank_write_counter #(.BUFFER_DEPTH(BUFFER_DEPTH)) bank_write_counter_i (
    .adc_clk, .adc_reset,
    .capture_start, .capture_stop, .capture_active, .active_channels,
    .write_en(write_en_now), .readout_done,
    .valid_mask, .write_addr, .bank_full(), .capture_full, .write_depth
  );

  sample_mux sample_mux_i (
    .adc_clk, .adc_in, .active_channels, .valid_mask, .capture_active,
    .write_en_now, .write_en, .write_data
  );

  sample_memory #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .READ_LATENCY(READ_LATENCY)
  ) sample_memory_i (
    .adc_clk, .write_en, .write_addr, .write_data,
    .read_en, .read_addr, .read_data
  );

  readout_stream #(
    .BUFFER_DEPTH(BUFFER_DEPTH),
    .READ_LATENCY(READ_LATENCY)
  ) readout_stream_i (
    .adc_clk, .adc_reset, .capture_done,
    .readout_start_valid, .readout_start_ready,
    .read_en, .read_addr, .read_data,
    .readout_data, .readout_valid, .readout_ready, .readout_done
  );

endmodule

//--- tb_buffer.sv
// testbench for the sample capture buffer, stimulus table, sample generator,
// reference model of the banked writes, checks and a cycle limit
`timescale 1ns/1ps
module tb_buffer;

  localparam int DEPTH = 16;
  localparam int LAT = 3;
  localparam int CH = buffer_pkg::CHANNELS;
  localparam int NUM_TESTS = 5;

  // one row of the stimulus table
  typedef struct packed {
    logic [1:0] mode;
    logic hw_start;
    // 0 runs until full
    logic [7:0] stop_after;
    logic all_valid;
    logic random_ready;
    logic expect_full;
  } test_row_t;

  logic adc_clk;
  logic adc_reset;
  buffer_pkg::adc_frame_t adc_in;
  logic capture_hw_start, capture_hw_stop, capture_full;
  buffer_pkg::capture_cmd_t cmd;
  logic cmd_valid, cmd_ready;
  buffer_pkg::bank_mode_t bank_mode;
  logic bank_mode_valid, bank_mode_ready;
  logic readout_start_valid, readout_start_ready;
  buffer_pkg::readout_beat_t readout_data;
  logic readout_valid, readout_ready;
  logic [CH-1:0][$clog2(DEPTH):0] write_depth;
  logic write_depth_valid;

  test_row_t tests [NUM_TESTS];
  logic [31:0] rand_state = 32'd49;
  int cycle_count = 0;
  int cycle_limit = 1000000;
  int total_checks = 0;
  int total_errors = 0;
  int test_checks, test_errors;

  // reference model state
  logic [15:0] shadow [CH][DEPTH];
  int model_count [CH];
  logic [CH-1:0] model_mask;
  logic model_open;
  int model_active;

  buffer_top #(.BUFFER_DEPTH(DEPTH), .READ_LATENCY(LAT)) dut_i (
    .adc_clk, .adc_reset, .adc_in, .capture_hw_start, .capture_hw_stop, .capture_full,
    .cmd, .cmd_valid, .cmd_ready, .bank_mode, .bank_mode_valid, .bank_mode_ready,
    .readout_start_valid, .readout_start_ready, .readout_data, .readout_valid,
    .readout_ready, .write_depth, .write_depth_valid
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  // run limit, also catches a missing handshake
  always @(posedge adc_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // lcg, upper half of the state
  function automatic logic [15:0] next_random();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state[31:16];
  endfunction

  function automatic test_row_t make_row(input logic [1:0] mode, input logic hw,
      input logic [7:0] stop, input logic all_v, input logic rnd, input logic full);
    test_row_t row;
    row.mode = mode;
    row.hw_start = hw;
    row.stop_after = stop;
    row.all_valid = all_v;
    row.random_ready = rnd;
    row.expect_full = full;
    return row;
  endfunction

  // capture and readout bound per row, doubled for margin
  function automatic int compute_cycle_limit();
    int sum;
    sum = 20;
    for (int i = 0; i < NUM_TESTS; i++) begin
      sum += 40 + LAT;
      if (tests[i].stop_after != 0) sum += tests[i].stop_after;
      else sum += CH * DEPTH * (tests[i].all_valid ? 1 : 4);
      sum += CH * DEPTH * (tests[i].random_ready ? 4 : 1);
    end
    return 2 * sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
      input logic [31:0] expected);
    test_checks++;
    total_checks++;
    if (got !== expected) begin
      test_errors++;
      total_errors++;
      $display("Error at %0t: %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  task automatic model_start(input int active);
    model_active = active;
    model_open = 1'b1;
    for (int b = 0; b < CH; b++) begin
      model_count[b] = 0;
      model_mask[b] = b < active;
    end
  endtask

  // bank b stores channel b mod active, a filled bank hands over to b + active
  task automatic model_frame(input buffer_pkg::adc_frame_t frame);
    logic [CH-1:0] next_mask;
    logic hit_full;
    int ch;
    if (model_open) begin
      next_mask = model_mask;
      hit_full = 1'b0;
      for (int b = 0; b < CH; b++) begin
        ch = b % model_active;
        if (model_mask[b] && frame.valid[ch]) begin
          shadow[b][model_count[b]] = frame.data[ch];
          model_count[b]++;
          if (model_count[b] == DEPTH) begin
            next_mask[b] = 1'b0;
            if (b + model_active < CH) next_mask[b + model_active] = 1'b1;
            // top banks form the full mask
            if (b >= CH - model_active) hit_full = 1'b1;
          end
        end
      end
      model_mask = next_mask;
      if (hit_full) model_open = 1'b0;
    end
  endtask

  task automatic drive_frame(input logic all_valid);
    logic [15:0] r;
    for (int c = 0; c < CH; c++) begin
      adc_in.data[c] = next_random();
    end
    r = next_random();
    adc_in.valid = all_valid ? '1 : r[11:8];
  endtask

  ////////////////////////////////////////
  // one table row, capture then readout
  ////////////////////////////////////////
  task automatic run_test(input int idx, input test_row_t row);
    int frames;
    int wait_cycles;
    int beats;
    int k;
    logic first_seen;
    logic ready_now;
    logic [15:0] r;
    test_checks = 0;
    test_errors = 0;
    @(negedge adc_clk);
    check_value("bank_mode_ready", bank_mode_ready, 1);
    check_value("cmd_ready", cmd_ready, 1);
    check_value("readout_start_ready", readout_start_ready, 0);
    bank_mode = row.mode;
    bank_mode_valid = 1'b1;
    @(negedge adc_clk);
    bank_mode_valid = 1'b0;
    cmd = '0;
    if (row.hw_start) begin
      cmd.arm = 1'b1;
      cmd_valid = 1'b1;
      @(negedge adc_clk);
      cmd_valid = 1'b0;
      cmd = '0;
      // armed, mode is locked
      check_value("bank_mode_ready", bank_mode_ready, 0);
      capture_hw_start = 1'b1;
    end else begin
      cmd.start = 1'b1;
      cmd_valid = 1'b1;
    end
    model_start(1 << row.mode);
    frames = 0;
    // first frame goes in with the start, one new frame per cycle
    while (!write_depth_valid) begin
      drive_frame(row.all_valid);
      if (row.stop_after != 0 && frames == row.stop_after) begin
        cmd.stop = 1'b1;
        cmd_valid = 1'b1;
        model_open = 1'b0;
      end else begin
        model_frame(adc_in);
      end
      frames++;
      @(negedge adc_clk);
      cmd_valid = 1'b0;
      cmd = '0;
      capture_hw_start = 1'b0;
    end
    for (int b = 0; b < CH; b++) begin
      check_value($sformatf("write_depth[%0d]", b), write_depth[b], model_count[b]);
    end
    check_value("capture_full", capture_full, row.expect_full);
    check_value("cmd_ready", cmd_ready, 0);
    check_value("bank_mode_ready", bank_mode_ready, 0);
    check_value("readout_start_ready", readout_start_ready, 0);
    wait_cycles = 0;
    while (!readout_start_ready) begin
      @(negedge adc_clk);
      wait_cycles++;
    end
    check_value("readout_start_ready delay", wait_cycles, 2);
    readout_start_valid = 1'b1;
    @(negedge adc_clk);
    readout_start_valid = 1'b0;
    k = 1;
    beats = 0;
    first_seen = 1'b0;
    // beat order is bank by bank, every address
    while (beats < CH * DEPTH) begin
      if (!first_seen && readout_valid) begin
        first_seen = 1'b1;
        check_value("readout latency", k - 1, LAT + 2);
      end
      r = next_random();
      ready_now = row.random_ready ? r[7] : 1'b1;
      readout_ready = ready_now;
      // valid and data hold until the next edge, so this beat is taken there
      if (readout_valid && ready_now) begin
        check_value("readout_data.data", readout_data.data, shadow[beats / DEPTH][beats % DEPTH]);
        check_value("readout_data.last", readout_data.last, beats == CH * DEPTH - 1);
        beats++;
      end
      @(negedge adc_clk);
      k++;
    end
    readout_ready = 1'b0;
    check_value("readout_valid", readout_valid, 0);
    $display("test %0d mode %0d: %0d frames, %0d checks, %0d errors",
             idx, row.mode, frames, test_checks, test_errors);
  endtask

  initial begin
    adc_reset = 1'b1;
    adc_in = '0;
    capture_hw_start = 1'b0;
    capture_hw_stop = 1'b0;
    cmd = '0;
    cmd_valid = 1'b0;
    bank_mode = '0;
    bank_mode_valid = 1'b0;
    readout_start_valid = 1'b0;
    readout_ready = 1'b0;
    // mode, hw start, stop after, all valid, random ready, full expected
    tests[0] = make_row(2'd2, 1'b0, 8'd0, 1'b1, 1'b0, 1'b1);
    tests[1] = make_row(2'd0, 1'b1, 8'd0, 1'b1, 1'b0, 1'b1);
    tests[2] = make_row(2'd1, 1'b0, 8'd10, 1'b1, 1'b0, 1'b0);
    tests[3] = make_row(2'd2, 1'b0, 8'd0, 1'b1, 1'b1, 1'b1);
    tests[4] = make_row(2'd1, 1'b1, 8'd0, 1'b0, 1'b1, 1'b1);
    cycle_limit = compute_cycle_limit();
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    adc_reset = 1'b0;
    test_checks = 0;
    test_errors = 0;
    @(negedge adc_clk);
    // control outputs right after reset
    check_value("capture_full", capture_full, 0);
    check_value("write_depth_valid", write_depth_valid, 0);
    check_value("readout_valid", readout_valid, 0);
    check_value("cmd_ready", cmd_ready, 1);
    check_value("bank_mode_ready", bank_mode_ready, 1);
    check_value("readout_start_ready", readout_start_ready, 0);
    $display("reset checks: %0d checks, %0d errors", test_checks, test_errors);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i, tests[i]);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, total_checks,
             total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sources.f
buffer_pkg.sv
capture_fsm.sv
bank_write_counter.sv
sample_mux.sv
sample_memory.sv
readout_stream.sv
buffer_top.sv
tb_buffer.sv

//--- Bender.yml
package:
  name: sample_capture_buffer

sources:
  - files:
      - buffer_pkg.sv
      - capture_fsm.sv
      - bank_write_counter.sv
      - sample_mux.sv
      - sample_memory.sv
      - readout_stream.sv
      - buffer_top.sv
  - target: test
    files:
      - tb_buffer.sv
